// ==== Bender.yml ====
package:
  name: ac97_audio

sources:
  - rtl/ac97_pkg.sv
  - rtl/sample_fifo.sv
  - rtl/ac97_codec_config.sv
  - rtl/ac97_pcm_unpacker.sv
  - rtl/ac97_link_tx.sv
  - rtl/ac97_audio_top.sv
  - target: test
    files:
      - dv/ac97_audio_tb.sv

// ==== dv/ac97_audio_tb.sv ====
`timescale 1ns/1ps

module ac97_audio_tb;
	import ac97_pkg::*;

	localparam int depth = 8;
	localparam logic [15:0] master_vol = 16'h1F1F;
	localparam logic [15:0] pcm_vol = 16'h0A0A;
	localparam int cycle_limit = 20000;  // About 45 frames plus margin

	logic ac97_bitclk;
	logic audio_rst_b;
	logic sample_valid;
	sample_word_t sample_word;
	logic sample_credit;
	logic ac97_sdata_out;
	logic ac97_sync;
	logic ac97_reset_b;

	int cycle_cnt;
	int credits;
	int checks[6];
	int fails[6];
	string test_name[6];
	logic [31:0] exp_pairs[$];  // {left, right} in play order
	logic [6:0] cfg_addr[7];
	logic [15:0] cfg_data[7];
	int cfg_seen;
	int pairs_seen;
	int idle_frames;  // Silent frames after configuration

	// Frame decoder state
	logic sync_prev;
	bit edge_seen;
	bit capturing;
	int last_rise;
	int high_len;
	int bit_idx;
	logic [frame_bits-1:0] frame;

	ac97_audio_top #(
		.fifo_depth(depth),
		.master_volume(master_vol),
		.pcm_volume(pcm_vol)
	) ac97_audio_top_i (
		.ac97_bitclk(ac97_bitclk),
		.audio_rst_b(audio_rst_b),
		.sample_valid(sample_valid),
		.sample_word(sample_word),
		.sample_credit(sample_credit),
		.ac97_sdata_out(ac97_sdata_out),
		.ac97_sync(ac97_sync),
		.ac97_reset_b(ac97_reset_b)
	);

	always #50 ac97_bitclk = ~ac97_bitclk;

	task automatic check(input int test, input string what, input logic [frame_bits-1:0] exp,
		input logic [frame_bits-1:0] act);
		checks[test]++;
		assert (act === exp) else begin
			fails[test]++;
			$display("[FAIL] %s %s expected %0h actual %0h", test_name[test], what, exp, act);
		end
	endtask

	// Source credit bookkeeping, inputs are stable at the edge
	always @(posedge ac97_bitclk) begin
		cycle_cnt++;
		credits = credits + int'(sample_credit) - int'(sample_valid);
		checks[5]++;
		assert (credits >= 0 && credits <= depth) else begin
			fails[5]++;
			$display("source credit counter left the range 0 to %0d, now %0d", depth, credits);
		end
		if (cycle_cnt >= cycle_limit) begin
			$display("timeout after %0d cycles, run did not complete", cycle_cnt);
			$display("** FAIL **");
			$finish;
		end
	end

	task automatic decode_frame();
		logic [15:0] tag;
		logic [19:0] s1;
		logic [19:0] s2;
		logic [19:0] s3;
		logic [19:0] s4;
		logic [31:0] pair;
		tag = frame[255:240];
		s1 = frame[239:220];
		s2 = frame[219:200];
		s3 = frame[199:180];
		s4 = frame[179:160];
		check(4, "unused slots", 0, frame[159:0]);
		check(4, "unused tag bits", 0, tag[10:0]);
		check(4, "tag bit 15", tag[14] | tag[12], tag[15]);
		if (tag[14]) begin
			check(2, "slot 2 tag", 1, tag[13]);
			if (cfg_seen >= 7) begin
				checks[2]++;
				fails[2]++;
				$display("extra configuration write after the table ended");
			end else begin
				check(2, "slot 1", {1'b0, cfg_addr[cfg_seen], 12'h000}, s1);
				check(2, "slot 2", {cfg_data[cfg_seen], 4'h0}, s2);
				cfg_seen++;
			end
		end else begin
			check(2, "slot 2 tag idle", 0, tag[13]);
			check(2, "slots 1 and 2 idle", 0, {s1, s2});
		end
		if (tag[12]) begin
			check(3, "slot 4 tag", 1, tag[11]);
			if (exp_pairs.size() == 0) begin
				checks[3]++;
				fails[3]++;
				$display("sample frame played with no word pushed");
			end else begin
				pair = exp_pairs.pop_front();
				check(3, "slot 3", {pair[31:16], 4'h0}, s3);
				check(3, "slot 4", {pair[15:0], 4'h0}, s4);
				pairs_seen++;
			end
		end else begin
			check(4, "slot 4 tag idle", 0, tag[11]);
			check(4, "slots 3 and 4 idle", 0, {s3, s4});
			if (cfg_seen == 7 && !tag[14]) begin
				idle_frames++;
			end
		end
	endtask

	// Sampled mid-cycle, away from the driving edge
	always @(negedge ac97_bitclk) begin
		if (audio_rst_b) begin
			if (ac97_sync && !sync_prev) begin
				if (edge_seen) begin
					check(1, "sync period", 256, cycle_cnt - last_rise);
				end
				edge_seen = 1;
				last_rise = cycle_cnt;
				high_len = 0;
				capturing = 1;
				bit_idx = 0;
			end
			if (!ac97_sync && sync_prev) begin
				check(1, "sync high length", tag_bits, high_len);
			end
			if (ac97_sync) begin
				high_len++;
			end
			if (capturing) begin
				frame[frame_bits-1-bit_idx] = ac97_sdata_out;
				bit_idx++;
				if (bit_idx == frame_bits) begin
					capturing = 0;
					decode_frame();
				end
			end
			sync_prev = ac97_sync;
		end
	end

	// Waits for a credit, then drives one word for one cycle
	task automatic push_sample(input sample_word_t w);
		while (credits <= 0) begin
			@(posedge ac97_bitclk);
			#1;
		end
		sample_valid = 1'b1;
		sample_word = w;
		// Pair A in the low 32 bits, left sample lowest
		exp_pairs.push_back({w[15:0], w[31:16]});
		exp_pairs.push_back({w[47:32], w[63:48]});
		@(posedge ac97_bitclk);
		#1;
		sample_valid = 1'b0;
	endtask

	task automatic wait_drained();
		while (exp_pairs.size() != 0) begin
			@(posedge ac97_bitclk);
		end
		repeat (3 * frame_bits) @(posedge ac97_bitclk);
		#1;
	endtask

	initial begin
		int total_checks;
		int total_fails;
		sample_word_t w;
		void'($urandom(43));
		ac97_bitclk = 1'b0;
		audio_rst_b = 1'b0;
		sample_valid = 1'b0;
		sample_word = '0;
		credits = depth;
		sync_prev = 1'b0;
		test_name = '{"reset", "framing", "config", "samples", "underrun", "credits"};
		cfg_addr = '{7'h02, 7'h0E, 7'h10, 7'h12, 7'h18, 7'h1A, 7'h1C};
		cfg_data = '{master_vol, 16'h8808, 16'h8808, 16'h8808, pcm_vol, 16'h0000, 16'h8000};

		repeat (10) begin
			@(posedge ac97_bitclk);
			#1;
			check(0, "outputs in reset", 0,
				{ac97_sync, ac97_sdata_out, sample_credit, ac97_reset_b});
		end
		audio_rst_b = 1'b1;
		@(posedge ac97_bitclk);
		#1;
		check(0, "codec reset released", 1, ac97_reset_b);

		// Full FIFO back to back, before any credit returns
		repeat (depth) begin
			w = {$urandom, $urandom};
			push_sample(w);
		end
		wait_drained();

		// Second batch with random idle gaps
		repeat (8) begin
			w = {$urandom, $urandom};
			push_sample(w);
			repeat ($urandom_range(0, 3)) @(posedge ac97_bitclk);
			#1;
		end
		wait_drained();

		check(2, "config writes seen", 7, cfg_seen);
		check(3, "pairs played", 32, pairs_seen);
		check(5, "credits at end", depth, credits);
		checks[4]++;
		assert (idle_frames > 0) else begin
			fails[4]++;
			$display("no silent frame seen after configuration");
		end

		total_checks = 0;
		total_fails = 0;
		for (int i = 0; i < 6; i++) begin
			$display("test %s: %0d checks, %0d failed", test_name[i], checks[i], fails[i]);
			total_checks += checks[i];
			total_fails += fails[i];
		end
		$display("checks passed %0d, failed %0d", total_checks - total_fails, total_fails);
		if (total_fails == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

// ==== project.f ====
rtl/ac97_pkg.sv
rtl/sample_fifo.sv
rtl/ac97_codec_config.sv
rtl/ac97_pcm_unpacker.sv
rtl/ac97_link_tx.sv
rtl/ac97_audio_top.sv
dv/ac97_audio_tb.sv

// ==== rtl/ac97_audio_top.sv ====
`timescale 1ns/1ps

module ac97_audio_top #(
	parameter int          fifo_depth = 512,
	parameter logic [15:0] master_volume = 16'h0000,
	parameter logic [15:0] pcm_volume = 16'h0808
) (
	input  logic                   ac97_bitclk,
	input  logic                   audio_rst_b,
	input  logic                   sample_valid,
	input  ac97_pkg::sample_word_t sample_word,
	output logic                   sample_credit,
	output logic                   ac97_sdata_out,
	output logic                   ac97_sync,
	output logic                   ac97_reset_b
);
	import ac97_pkg::*;

	sample_word_t head_word;
	logic fifo_empty;
	logic fifo_pop;
	logic frame_strobe;  // Last bit of each frame
	ac97_pcm_t pcm;
	ac97_cmd_t cmd;

	sample_fifo #(.fifo_depth(fifo_depth)) sample_fifo_i (
		.ac97_bitclk(ac97_bitclk),
		.audio_rst_b(audio_rst_b),
		.push(sample_valid),
		.push_word(sample_word),
		.pop(fifo_pop),
		.head_word(head_word),
		.empty(fifo_empty),
		.credit(sample_credit)
	);

	ac97_pcm_unpacker ac97_pcm_unpacker_i (
		.ac97_bitclk(ac97_bitclk),
		.audio_rst_b(audio_rst_b),
		.frame_strobe(frame_strobe),
		.empty(fifo_empty),
		.head_word(head_word),
		.pop(fifo_pop),
		.pcm(pcm)
	);

	ac97_codec_config #(
		.master_volume(master_volume),
		.pcm_volume(pcm_volume)
	) ac97_codec_config_i (
		.ac97_bitclk(ac97_bitclk),
		.audio_rst_b(audio_rst_b),
		.frame_strobe(frame_strobe),
		.cmd(cmd)
	);

	ac97_link_tx ac97_link_tx_i (
		.ac97_bitclk(ac97_bitclk),
		.audio_rst_b(audio_rst_b),
		.cmd(cmd),
		.pcm(pcm),
		.frame_strobe(frame_strobe),
		.ac97_sdata_out(ac97_sdata_out),
		.ac97_sync(ac97_sync),
		.ac97_reset_b(ac97_reset_b)
	);

endmodule

// ==== rtl/ac97_codec_config.sv ====
`timescale 1ns/1ps

module ac97_codec_config #(
	parameter logic [15:0] master_volume = 16'h0000,
	parameter logic [15:0] pcm_volume = 16'h0808
) (
	input  logic                ac97_bitclk,
	input  logic                audio_rst_b,
	input  logic                frame_strobe,
	output ac97_pkg::ac97_cmd_t cmd
);
	import ac97_pkg::*;

	logic [2:0] wr_idx;  // Next table entry

	// Write table in the order the codec gets it
	always_comb begin
		cmd = '0;
		cmd.valid = 1'b1;
		case (wr_idx)
			3'd0: begin
				cmd.addr = reg_master_volume;
				cmd.data = master_volume;
			end
			3'd1: begin
				cmd.addr = reg_mic_volume;
				cmd.data = mute_8808;
			end
			3'd2: begin
				cmd.addr = reg_line_in_volume;
				cmd.data = mute_8808;
			end
			3'd3: begin
				cmd.addr = reg_cd_volume;
				cmd.data = mute_8808;
			end
			3'd4: begin
				cmd.addr = reg_pcm_volume;
				cmd.data = pcm_volume;
			end
			3'd5: begin
				cmd.addr = reg_record_select;
				cmd.data = record_select_default;
			end
			3'd6: begin
				cmd.addr = reg_record_gain;
				cmd.data = record_gain_default;
			end
			default: cmd = '0;  // Table done, slots 1 and 2 idle
		endcase
	end

	// Holds at the end until the next reset
	always_ff @(posedge ac97_bitclk or negedge audio_rst_b) begin
		if (!audio_rst_b) begin
			wr_idx <= '0;
		end else if (frame_strobe && wr_idx != 3'(config_writes)) begin
			wr_idx <= wr_idx + 3'd1;
		end
	end

endmodule

// ==== rtl/ac97_link_tx.sv ====
`timescale 1ns/1ps

module ac97_link_tx (
	input  logic                ac97_bitclk,
	input  logic                audio_rst_b,
	input  ac97_pkg::ac97_cmd_t cmd,
	input  ac97_pkg::ac97_pcm_t pcm,
	output logic                frame_strobe,
	output logic                ac97_sdata_out,
	output logic                ac97_sync,
	output logic                ac97_reset_b
);
	import ac97_pkg::*;

	localparam int unused_bits = frame_bits - tag_bits - 4 * slot_bits;

	logic [7:0] bit_cnt;  // Index of the next bit to send
	logic [frame_bits-1:0] shift_q;
	logic [frame_bits-1:0] frame_next;
	logic [tag_bits-1:0] tag;
	slot_t slot1;
	slot_t slot2;
	slot_t slot3;
	slot_t slot4;

	// Counter has wrapped, so bit 255 is on the wire now
	assign frame_strobe = ac97_reset_b && (bit_cnt == 8'd0);

	// Next frame from the current cmd and pcm
	always_comb begin
		tag = '0;
		slot1 = '0;
		slot2 = '0;
		slot3 = '0;
		slot4 = '0;
		if (cmd.valid) begin
			tag[14] = 1'b1;
			tag[13] = 1'b1;
			slot1 = {1'b0, cmd.addr, 12'h000};  // Write access
			slot2 = {cmd.data, 4'h0};
		end
		if (pcm.valid) begin
			tag[12] = 1'b1;
			tag[11] = 1'b1;
			slot3 = {pcm.left, 4'h0};
			slot4 = {pcm.right, 4'h0};
		end
		tag[15] = cmd.valid | pcm.valid;  // Frame valid
		frame_next = {tag, slot1, slot2, slot3, slot4, {unused_bits{1'b0}}};
	end

	// First frame after reset shifts out the cleared register
	always_ff @(posedge ac97_bitclk or negedge audio_rst_b) begin
		if (!audio_rst_b) begin
			bit_cnt <= '0;
			shift_q <= '0;
			ac97_sdata_out <= 1'b0;
			ac97_sync <= 1'b0;
			ac97_reset_b <= 1'b0;
		end else begin
			ac97_reset_b <= 1'b1;  // Codec out of reset
			bit_cnt <= bit_cnt + 8'd1;
			ac97_sync <= (bit_cnt < 8'(tag_bits));
			if (frame_strobe) begin
				ac97_sdata_out <= frame_next[frame_bits-1];
				shift_q <= {frame_next[frame_bits-2:0], 1'b0};
			end else begin
				ac97_sdata_out <= shift_q[frame_bits-1];
				shift_q <= {shift_q[frame_bits-2:0], 1'b0};
			end
		end
	end

endmodule

// ==== rtl/ac97_pcm_unpacker.sv ====
`timescale 1ns/1ps

module ac97_pcm_unpacker (
	input  logic                   ac97_bitclk,
	input  logic                   audio_rst_b,
	input  logic                   frame_strobe,
	input  logic                   empty,
	input  ac97_pkg::sample_word_t head_word,
	output logic                   pop,
	output ac97_pkg::ac97_pcm_t    pcm
);
	import ac97_pkg::*;

	sample_word_t word_q;  // Word whose pair B is still to play
	logic second_half;

	// New word only when pair A is due
	assign pop = frame_strobe && second_half && !empty;

	always_comb begin
		pcm = '0;
		if (!second_half) begin
			pcm.valid = 1'b1;
			pcm.left = word_q.left_b;
			pcm.right = word_q.right_b;
		end else if (!empty) begin
			// Pair A straight from the FIFO head
			pcm.valid = 1'b1;
			pcm.left = head_word.left_a;
			pcm.right = head_word.right_a;
		end
	end

	always_ff @(posedge ac97_bitclk) begin
		if (pop) begin
			word_q <= head_word;
		end
	end

	// Empty FIFO leaves the phase alone, frame goes out silent
	always_ff @(posedge ac97_bitclk or negedge audio_rst_b) begin
		if (!audio_rst_b) begin
			second_half <= 1'b1;
		end else if (pop) begin
			second_half <= 1'b0;
		end else if (frame_strobe) begin
			second_half <= 1'b1;
		end
	end

endmodule

// ==== rtl/ac97_pkg.sv ====
package ac97_pkg;

	// AC-link frame timing
	localparam int frame_bits = 256;
	localparam int tag_bits = 16;  // Slot 0 width, also SYNC length
	localparam int slot_bits = 20;
	localparam int slot_count = 12;  // Data slots following the tag

	typedef logic [slot_bits-1:0] slot_t;

	// Two stereo frames per word, pair A in the low half
	typedef struct packed {
		logic [15:0] right_b;
		logic [15:0] left_b;
		logic [15:0] right_a;
		logic [15:0] left_a;
	} sample_word_t;

	// Stereo pair for slots 3 and 4
	typedef struct packed {
		logic        valid;
		logic [15:0] left;
		logic [15:0] right;
	} ac97_pcm_t;

	// Register write for slots 1 and 2
	typedef struct packed {
		logic        valid;
		logic [6:0]  addr;
		logic [15:0] data;
	} ac97_cmd_t;

	// Codec mixer registers
	localparam logic [6:0] reg_master_volume = 7'h02;
	localparam logic [6:0] reg_mic_volume = 7'h0E;
	localparam logic [6:0] reg_line_in_volume = 7'h10;
	localparam logic [6:0] reg_cd_volume = 7'h12;
	localparam logic [6:0] reg_pcm_volume = 7'h18;
	localparam logic [6:0] reg_record_select = 7'h1A;
	localparam logic [6:0] reg_record_gain = 7'h1C;

	// Fixed register values
	localparam logic [15:0] mute_8808 = 16'h8808;  // Muted, mid gain
	localparam logic [15:0] record_select_default = 16'h0000;
	localparam logic [15:0] record_gain_default = 16'h8000;

	localparam int config_writes = 7;

endpackage

// ==== rtl/sample_fifo.sv ====
`timescale 1ns/1ps

module sample_fifo #(
	parameter int fifo_depth = 512
) (
	input  logic                  ac97_bitclk,
	input  logic                  audio_rst_b,
	input  logic                  push,
	input  ac97_pkg::sample_word_t push_word,
	input  logic                  pop,
	output ac97_pkg::sample_word_t head_word,
	output logic                  empty,
	output logic                  credit
);
	import ac97_pkg::*;

	localparam int ptr_bits = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
	localparam int cnt_bits = $clog2(fifo_depth + 1);

	sample_word_t mem [fifo_depth];
	logic [ptr_bits-1:0] wr_ptr;
	logic [ptr_bits-1:0] rd_ptr;
	logic [cnt_bits-1:0] count;  // Words held

	// Wrap for depths that are not a power of two
	function automatic logic [ptr_bits-1:0] ptr_inc(input logic [ptr_bits-1:0] ptr);
		if (ptr == ptr_bits'(fifo_depth - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	// Source never pushes without a credit, so no full check
	always_ff @(posedge ac97_bitclk) begin
		if (push) begin
			mem[wr_ptr] <= push_word;
		end
	end

	always_ff @(posedge ac97_bitclk or negedge audio_rst_b) begin
		if (!audio_rst_b) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			credit <= 1'b0;
		end else begin
			credit <= pop;  // One credit back per word taken
			if (push) begin
				wr_ptr <= ptr_inc(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= ptr_inc(rd_ptr);
			end
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Show-ahead head
	assign head_word = mem[rd_ptr];
	assign empty = (count == '0);

endmodule
